//--- cpu_core.f
hw/isa_pkg.sv
hw/sched_pkg.sv
hw/cpu_ifs.sv
hw/front_end.sv
hw/scoreboard.sv
hw/alu_unit.sv
hw/register_file.sv
hw/cpu_core.sv
tests/cpu_core_properties.sv
tests/cpu_core_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpu_core_tb -Mdir obj_dir -f cpu_core.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vcpu_core_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	exit 1
fi
exit 0

//--- tests/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb
	import isa_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int ROM_DEPTH = 256;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 64;
	localparam int MAX_CYCLES = NUM_TESTS * CYCLES_PER_TEST;
	localparam int DRAIN_LIMIT = 40;
	localparam int QUIET_CYCLES = 4;

	logic     clk;
	logic     rst;
	word_t    fetch_addr;
	instr_t   instruction;
	logic     stall;
	logic     wb0_valid;
	logic     wb1_valid;
	reg_idx_t wb0_rd;
	reg_idx_t wb1_rd;
	word_t    wb0_value;
	word_t    wb1_value;
	reg_idx_t dbg_addr;
	word_t    dbg_value;

	instr_t   rom [ROM_DEPTH];
	word_t    rom_addr;
	word_t    model_regs [NUM_REGS];
	reg_idx_t exp_rd[$];
	word_t    exp_value[$];
	reg_idx_t seen_rd[$];
	word_t    seen_value[$];
	int       stall_cycles;
	int       cycle_count;
	int       checks;
	int       errors;
	int       test_errors;
	int       tests_run;

	cpu_core cpu_core_inst (
		.clk         (clk),
		.rst         (rst),
		.fetch_addr  (fetch_addr),
		.instruction (instruction),
		.stall       (stall),
		.wb0_valid   (wb0_valid),
		.wb1_valid   (wb1_valid),
		.wb0_rd      (wb0_rd),
		.wb1_rd      (wb1_rd),
		.wb0_value   (wb0_value),
		.wb1_value   (wb1_value),
		.dbg_addr    (dbg_addr),
		.dbg_value   (dbg_value)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// program rom and monitors
	//////////////////////////////////////////////////////////////////////

	// unknown opcode tagged with its address
	function automatic instr_t filler(input int a);
		return {5'b11111, 3'b000, a[7:0]};
	endfunction

	function automatic instr_t rom_word(input word_t addr);
		if (addr < ROM_DEPTH) begin
			return rom[addr[7:0]];
		end
		return {5'b11111, addr[10:0]};
	endfunction

	// answers the address seen in the previous cycle
	initial begin
		rom_addr = '0;
		forever begin
			@(posedge clk);
			#1;
			instruction = rom_word(rom_addr);
			rom_addr = fetch_addr;
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			if (wb0_valid) begin
				seen_rd.push_back(wb0_rd);
				seen_value.push_back(wb0_value);
			end
			if (wb1_valid) begin
				seen_rd.push_back(wb1_rd);
				seen_value.push_back(wb1_value);
			end
			if (stall) begin
				stall_cycles++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", MAX_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// program building and reference model
	//////////////////////////////////////////////////////////////////////

	function automatic instr_t encode_imm(input opcode_t op, input reg_idx_t rd,
		input reg_idx_t rs, input int imm);
		return {op, rd, rs, imm[4:0]};
	endfunction

	function automatic instr_t encode_reg(input opcode_t op, input reg_idx_t rd,
		input reg_idx_t rs, input reg_idx_t rt);
		return {op, rd, rs, 2'b00, rt};
	endfunction

	task automatic load_program(input instr_t prog[$]);
		for (int a = 0; a < ROM_DEPTH; a++) begin
			rom[a] = filler(a);
		end
		foreach (prog[i]) begin
			rom[i] = prog[i];
		end
	endtask

	// in-order execution that skips words with other opcodes
	task automatic run_model(input instr_t prog[$]);
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
		word_t    imm;
		word_t    result;
		logic     known;
		foreach (model_regs[r]) begin
			model_regs[r] = '0;
		end
		exp_rd = {};
		exp_value = {};
		foreach (prog[i]) begin
			rd = prog[i][RD_LSB +: 3];
			rs = prog[i][RS_LSB +: 3];
			rt = prog[i][RT_LSB +: 3];
			imm = {{11{prog[i][4]}}, prog[i][4:0]};
			known = 1'b1;
			result = '0;
			case (prog[i][OPC_MSB:OPC_LSB])
				OP_ADDI: result = model_regs[rs] + imm;
				OP_ADD: result = model_regs[rs] + model_regs[rt];
				OP_SUBI: result = model_regs[rs] - imm;
				OP_SUB: result = model_regs[rs] - model_regs[rt];
				default: known = 1'b0;
			endcase
			if (known) begin
				model_regs[rd] = result;
				exp_rd.push_back(rd);
				exp_value.push_back(result);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// run control
	//////////////////////////////////////////////////////////////////////

	task automatic start_program(input instr_t prog[$]);
		load_program(prog);
		run_model(prog);
		@(posedge clk);
		#1;
		rst = 1'b1;
		seen_rd = {};
		seen_value = {};
		stall_cycles = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	// wait for every expected writeback, then watch for extra ones
	task automatic drain();
		int waited;
		waited = 0;
		while (seen_rd.size() < exp_rd.size() && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (seen_rd.size() < exp_rd.size()) begin
			$display("%0t: writebacks stopped at %0d of %0d after %0d cycles", $time,
				seen_rd.size(), exp_rd.size(), waited);
			test_errors++;
		end
		repeat (QUIET_CYCLES) @(posedge clk);
		#1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic compare_word(input string name, input word_t got, input word_t expected);
		checks++;
		if (got !== expected) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
			test_errors++;
		end
	endtask

	task automatic compare_reg(input string name, input reg_idx_t got,
		input reg_idx_t expected);
		checks++;
		if (got !== expected) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, expected);
			test_errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic expected);
		checks++;
		if (got !== expected) begin
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, expected);
			test_errors++;
		end
	endtask

	task automatic check_wb_count();
		checks++;
		if (seen_rd.size() != exp_rd.size()) begin
			$display("%0t: saw %0d writebacks where %0d were expected", $time,
				seen_rd.size(), exp_rd.size());
			test_errors++;
		end
	endtask

	task automatic check_writebacks_in_order();
		for (int i = 0; i < exp_rd.size() && i < seen_rd.size(); i++) begin
			compare_reg($sformatf("wb_rd[%0d]", i), seen_rd[i], exp_rd[i]);
			compare_word($sformatf("wb_value[%0d]", i), seen_value[i], exp_value[i]);
		end
	endtask

	// each expected pair must show up exactly once
	task automatic check_writebacks_any_order();
		reg_idx_t left_rd[$];
		word_t    left_value[$];
		int       hit;
		left_rd = seen_rd;
		left_value = seen_value;
		foreach (exp_rd[i]) begin
			hit = -1;
			checks++;
			foreach (left_rd[j]) begin
				if (hit < 0 && left_rd[j] == exp_rd[i] && left_value[j] == exp_value[i]) begin
					hit = j;
				end
			end
			if (hit < 0) begin
				$display("%0t: writeback r%0d = %h never appeared", $time,
					exp_rd[i], exp_value[i]);
				test_errors++;
			end else begin
				left_rd.delete(hit);
				left_value.delete(hit);
			end
		end
		foreach (left_rd[j]) begin
			$display("%0t: unexpected writeback r%0d = %h", $time, left_rd[j], left_value[j]);
			test_errors++;
		end
	endtask

	task automatic check_registers();
		for (int r = 0; r < NUM_REGS; r++) begin
			@(posedge clk);
			#1;
			dbg_addr = reg_idx_t'(r);
			@(negedge clk);
			compare_word($sformatf("dbg_value[r%0d]", r), dbg_value, model_regs[r]);
		end
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, test_errors);
		end
		errors += test_errors;
		test_errors = 0;
		tests_run++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		instr_t prog[$];
		start_program(prog);
		@(negedge clk);
		compare_bit("stall", stall, 1'b0);
		compare_bit("wb0_valid", wb0_valid, 1'b0);
		compare_bit("wb1_valid", wb1_valid, 1'b0);
		compare_word("fetch_addr", fetch_addr, 16'd0);
		// nothing stalls, so the next fetch follows
		@(negedge clk);
		compare_word("fetch_addr", fetch_addr, 16'd1);
		drain();
		check_wb_count();
		check_registers();
		report_test("reset_state");
	endtask

	task automatic test_immediate_forms();
		instr_t prog[$];
		prog.push_back(encode_imm(OP_ADDI, 3'd1, 3'd0, 15));
		prog.push_back(encode_imm(OP_ADDI, 3'd2, 3'd0, -16));
		prog.push_back(encode_imm(OP_SUBI, 3'd3, 3'd0, 1));
		prog.push_back(encode_imm(OP_SUBI, 3'd4, 3'd0, -5));
		prog.push_back(encode_imm(OP_ADDI, 3'd5, 3'd2, -1));
		prog.push_back(encode_imm(OP_SUBI, 3'd6, 3'd1, 15));
		// wraps to zero
		prog.push_back(encode_imm(OP_ADDI, 3'd7, 3'd3, 1));
		start_program(prog);
		drain();
		check_wb_count();
		check_writebacks_any_order();
		check_registers();
		report_test("immediate_forms");
	endtask

	// every instruction reads the result of the one before
	task automatic test_raw_chain();
		instr_t prog[$];
		prog.push_back(encode_imm(OP_ADDI, 3'd1, 3'd0, 7));
		prog.push_back(encode_imm(OP_ADDI, 3'd2, 3'd1, 3));
		prog.push_back(encode_reg(OP_ADD, 3'd3, 3'd1, 3'd2));
		prog.push_back(encode_reg(OP_SUB, 3'd4, 3'd1, 3'd3));
		prog.push_back(encode_reg(OP_ADD, 3'd5, 3'd4, 3'd3));
		prog.push_back(encode_reg(OP_SUB, 3'd6, 3'd5, 3'd2));
		prog.push_back(encode_reg(OP_ADD, 3'd7, 3'd6, 3'd6));
		prog.push_back(encode_reg(OP_SUB, 3'd1, 3'd7, 3'd4));
		start_program(prog);
		drain();
		check_wb_count();
		check_writebacks_in_order();
		check_registers();
		report_test("raw_chain");
	endtask

	task automatic test_write_after_write();
		instr_t prog[$];
		prog.push_back(encode_imm(OP_ADDI, 3'd3, 3'd0, 9));
		prog.push_back(encode_imm(OP_ADDI, 3'd3, 3'd0, 4));
		prog.push_back(encode_reg(OP_ADD, 3'd2, 3'd3, 3'd3));
		start_program(prog);
		drain();
		compare_bit("stall seen", stall_cycles > 0, 1'b1);
		check_wb_count();
		check_writebacks_any_order();
		check_registers();
		report_test("write_after_write");
	endtask

	task automatic test_parallel_units();
		instr_t prog[$];
		prog.push_back(encode_imm(OP_ADDI, 3'd1, 3'd0, 11));
		prog.push_back(encode_imm(OP_SUBI, 3'd2, 3'd0, 7));
		start_program(prog);
		drain();
		check_wb_count();
		check_writebacks_any_order();
		check_registers();
		report_test("parallel_units");
	endtask

	task automatic test_unknown_opcodes();
		instr_t prog[$];
		prog.push_back(encode_imm(OP_ADDI, 3'd1, 3'd0, 3));
		prog.push_back(16'h2245);
		prog.push_back(encode_imm(OP_ADDI, 3'd2, 3'd1, 2));
		prog.push_back(16'hF9E3);
		prog.push_back(16'h8922);
		prog.push_back(encode_reg(OP_SUB, 3'd4, 3'd2, 3'd1));
		start_program(prog);
		drain();
		check_wb_count();
		check_writebacks_any_order();
		check_registers();
		report_test("unknown_opcodes");
	endtask

	initial begin
		int total;
		rst = 1'b1;
		instruction = '0;
		dbg_addr = '0;
		cycle_count = 0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		stall_cycles = 0;
		test_reset_state();
		test_immediate_forms();
		test_raw_chain();
		test_write_after_write();
		test_parallel_units();
		test_unknown_opcodes();
		total = errors + int'(cpu_core_inst.properties_inst.violations);
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests_run,
			checks, errors, cpu_core_inst.properties_inst.violations);
		if (total == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- tests/cpu_core_properties.sv
`timescale 1ns/1ps

module cpu_core_properties
	import isa_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input logic     stall,
	input logic     wb0_valid,
	input logic     wb1_valid,
	input reg_idx_t wb0_rd,
	input reg_idx_t wb1_rd,
	input word_t    fetch_addr
);

	// read by the testbench at the end of the run
	int unsigned violations = 0;

	// nothing is decoded in the first cycle out of reset
	stall_low_after_reset: assert property (@(posedge clk) rst |=> !stall)
		else begin
			$error("stall high in the first cycle after reset");
			violations++;
		end

	// single writer per register
	wb_distinct_rd: assert property (@(posedge clk) disable iff (rst)
		!(wb0_valid && wb1_valid && wb0_rd == wb1_rd))
		else begin
			$error("both writeback ports target r%0d", wb0_rd);
			violations++;
		end

	fetch_holds_on_stall: assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable(fetch_addr))
		else begin
			$error("fetch_addr moved while stall was high");
			violations++;
		end

endmodule

bind cpu_core cpu_core_properties properties_inst (
	.clk        (clk),
	.rst        (rst),
	.stall      (stall),
	.wb0_valid  (wb0_valid),
	.wb1_valid  (wb1_valid),
	.wb0_rd     (wb0_rd),
	.wb1_rd     (wb1_rd),
	.fetch_addr (fetch_addr)
);

//--- hw/cpu_core.sv
`timescale 1ns/1ps

module cpu_core
	import isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	output word_t    fetch_addr,
	input  instr_t   instruction,
	output logic     stall,
	output logic     wb0_valid,
	output logic     wb1_valid,
	output reg_idx_t wb0_rd,
	output reg_idx_t wb1_rd,
	output word_t    wb0_value,
	output word_t    wb1_value,
	input  reg_idx_t dbg_addr,
	output word_t    dbg_value
);

	issue_if    iss ();
	dispatch_if disp0 ();
	dispatch_if disp1 ();

	reg_idx_t rd_addr_a0;
	reg_idx_t rd_addr_b0;
	reg_idx_t rd_addr_a1;
	reg_idx_t rd_addr_b1;
	word_t    rd_data_a0;
	word_t    rd_data_b0;
	word_t    rd_data_a1;
	word_t    rd_data_b1;

	assign stall = iss.stall;

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////

	front_end u_front_end (
		.clk         (clk),
		.rst         (rst),
		.fetch_addr  (fetch_addr),
		.instruction (instruction),
		.iss         (iss.source)
	);

	//////////////////////////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////////////////////////

	scoreboard u_scoreboard (
		.clk        (clk),
		.rst        (rst),
		.iss        (iss.sink),
		.alu0       (disp0.issuer),
		.alu1       (disp1.issuer),
		.rd_addr_a0 (rd_addr_a0),
		.rd_addr_b0 (rd_addr_b0),
		.rd_addr_a1 (rd_addr_a1),
		.rd_addr_b1 (rd_addr_b1),
		.rd_data_a0 (rd_data_a0),
		.rd_data_b0 (rd_data_b0),
		.rd_data_a1 (rd_data_a1),
		.rd_data_b1 (rd_data_b1),
		.wb0_valid  (wb0_valid),
		.wb0_rd     (wb0_rd),
		.wb1_valid  (wb1_valid),
		.wb1_rd     (wb1_rd)
	);

	alu_unit u_alu0 (
		.clk      (clk),
		.rst      (rst),
		.disp     (disp0.unit),
		.wb_valid (wb0_valid),
		.wb_rd    (wb0_rd),
		.wb_value (wb0_value)
	);

	alu_unit u_alu1 (
		.clk      (clk),
		.rst      (rst),
		.disp     (disp1.unit),
		.wb_valid (wb1_valid),
		.wb_rd    (wb1_rd),
		.wb_value (wb1_value)
	);

	//////////////////////////////////////////////////////////////////////
	// result
	//////////////////////////////////////////////////////////////////////

	register_file u_register_file (
		.clk        (clk),
		.rst        (rst),
		.rd_addr_a0 (rd_addr_a0),
		.rd_addr_b0 (rd_addr_b0),
		.rd_addr_a1 (rd_addr_a1),
		.rd_addr_b1 (rd_addr_b1),
		.rd_data_a0 (rd_data_a0),
		.rd_data_b0 (rd_data_b0),
		.rd_data_a1 (rd_data_a1),
		.rd_data_b1 (rd_data_b1),
		.dbg_addr   (dbg_addr),
		.dbg_value  (dbg_value),
		.wb0_valid  (wb0_valid),
		.wb0_rd     (wb0_rd),
		.wb0_value  (wb0_value),
		.wb1_valid  (wb1_valid),
		.wb1_rd     (wb1_rd),
		.wb1_value  (wb1_value)
	);

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ps

module register_file
	import isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t rd_addr_a0,
	input  reg_idx_t rd_addr_b0,
	input  reg_idx_t rd_addr_a1,
	input  reg_idx_t rd_addr_b1,
	output word_t    rd_data_a0,
	output word_t    rd_data_b0,
	output word_t    rd_data_a1,
	output word_t    rd_data_b1,
	input  reg_idx_t dbg_addr,
	output word_t    dbg_value,
	input  logic     wb0_valid,
	input  reg_idx_t wb0_rd,
	input  word_t    wb0_value,
	input  logic     wb1_valid,
	input  reg_idx_t wb1_rd,
	input  word_t    wb1_value
);

	word_t regs [NUM_REGS];

	// write-to-read bypass
	function automatic word_t read_port(input reg_idx_t addr);
		word_t value;
		value = regs[addr];
		if (wb0_valid && wb0_rd == addr) begin
			value = wb0_value;
		end
		if (wb1_valid && wb1_rd == addr) begin
			value = wb1_value;
		end
		return value;
	endfunction

	always_comb begin
		rd_data_a0 = read_port(rd_addr_a0);
		rd_data_b0 = read_port(rd_addr_b0);
		rd_data_a1 = read_port(rd_addr_a1);
		rd_data_b1 = read_port(rd_addr_b1);
		dbg_value = read_port(dbg_addr);
	end

	// scoreboard keeps the two ports on different registers
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			if (wb0_valid) begin
				regs[wb0_rd] <= wb0_value;
			end
			if (wb1_valid) begin
				regs[wb1_rd] <= wb1_value;
			end
		end
	end

endmodule

//--- hw/alu_unit.sv
`timescale 1ns/1ps

module alu_unit
	import isa_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	dispatch_if.unit   disp,
	output logic       wb_valid,
	output reg_idx_t   wb_rd,
	output word_t      wb_value
);

	// result pulse one cycle after the start strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= disp.start;
		end
	end

	// wraps modulo 2^16
	always_ff @(posedge clk) begin
		if (disp.start) begin
			wb_rd <= disp.rd;
			if (disp.op == ALU_SUB) begin
				wb_value <= disp.operand_a - disp.operand_b;
			end else begin
				wb_value <= disp.operand_a + disp.operand_b;
			end
		end
	end

endmodule

//--- hw/scoreboard.sv
`timescale 1ns/1ps

module scoreboard
	import isa_pkg::*;
	import sched_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	issue_if.sink      iss,
	dispatch_if.issuer alu0,
	dispatch_if.issuer alu1,
	output reg_idx_t   rd_addr_a0,
	output reg_idx_t   rd_addr_b0,
	output reg_idx_t   rd_addr_a1,
	output reg_idx_t   rd_addr_b1,
	input  word_t      rd_data_a0,
	input  word_t      rd_data_b0,
	input  word_t      rd_data_a1,
	input  word_t      rd_data_b1,
	input  logic       wb0_valid,
	input  reg_idx_t   wb0_rd,
	input  logic       wb1_valid,
	input  reg_idx_t   wb1_rd
);

	// unit status table
	unit_state_t    u_state  [NUM_ALUS];
	alu_op_t        u_op     [NUM_ALUS];
	reg_idx_t       u_rd     [NUM_ALUS];
	reg_idx_t       u_src_a  [NUM_ALUS];
	reg_idx_t       u_src_b  [NUM_ALUS];
	unit_id_t       u_prod_a [NUM_ALUS];
	unit_id_t       u_prod_b [NUM_ALUS];
	operand_state_t u_opnd_a [NUM_ALUS];
	operand_state_t u_opnd_b [NUM_ALUS];
	word_t          u_imm    [NUM_ALUS];

	// register result status
	logic     reg_pending  [NUM_REGS];
	unit_id_t reg_producer [NUM_REGS];

	logic     wb_valid [NUM_ALUS];
	reg_idx_t wb_rd    [NUM_ALUS];
	word_t    data_a   [NUM_ALUS];
	word_t    data_b   [NUM_ALUS];
	word_t    opnd_b   [NUM_ALUS];
	logic     disp_go  [NUM_ALUS];

	logic     any_free;
	unit_id_t free_unit;
	logic     issue_go;
	logic     src_a_wait;
	logic     src_b_wait;

	assign wb_valid[0] = wb0_valid;
	assign wb_valid[1] = wb1_valid;
	assign wb_rd[0] = wb0_rd;
	assign wb_rd[1] = wb1_rd;
	assign data_a[0] = rd_data_a0;
	assign data_a[1] = rd_data_a1;
	assign data_b[0] = rd_data_b0;
	assign data_b[1] = rd_data_b1;

	// register is being written back right now
	function automatic logic wb_hit(input reg_idx_t r);
		return (wb0_valid && wb0_rd == r) || (wb1_valid && wb1_rd == r);
	endfunction

	// usable now, either settled or arriving on the bypass
	function automatic logic opnd_ok(input operand_state_t st, input unit_id_t prod);
		return (st != OPND_PENDING) || wb_valid[prod];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// issue
	//////////////////////////////////////////////////////////////////////

	// downward scan so the lowest free unit wins
	always_comb begin
		any_free = 1'b0;
		free_unit = '0;
		for (int u = NUM_ALUS - 1; u >= 0; u--) begin
			if (u_state[u] == UNIT_FREE) begin
				any_free = 1'b1;
				free_unit = unit_id_t'(u);
			end
		end
	end

	// waw hazard or no unit -> hold the front end
	assign iss.stall = iss.valid && (!any_free || reg_pending[iss.rd]);
	assign issue_go = iss.valid && !iss.stall;

	// a writeback in this cycle lands before the new entry can listen
	assign src_a_wait = reg_pending[iss.rs] && !wb_hit(iss.rs);
	assign src_b_wait = !iss.use_imm && reg_pending[iss.rt] && !wb_hit(iss.rt);

	//////////////////////////////////////////////////////////////////////
	// dispatch
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int u = 0; u < NUM_ALUS; u++) begin
			disp_go[u] = (u_state[u] == UNIT_WAITING)
				&& opnd_ok(u_opnd_a[u], u_prod_a[u])
				&& opnd_ok(u_opnd_b[u], u_prod_b[u]);
			opnd_b[u] = (u_opnd_b[u] == OPND_IMMEDIATE) ? u_imm[u] : data_b[u];
		end
	end

	assign rd_addr_a0 = u_src_a[0];
	assign rd_addr_b0 = u_src_b[0];
	assign rd_addr_a1 = u_src_a[1];
	assign rd_addr_b1 = u_src_b[1];

	assign alu0.start = disp_go[0];
	assign alu0.op = u_op[0];
	assign alu0.operand_a = data_a[0];
	assign alu0.operand_b = opnd_b[0];
	assign alu0.rd = u_rd[0];

	assign alu1.start = disp_go[1];
	assign alu1.op = u_op[1];
	assign alu1.operand_a = data_a[1];
	assign alu1.operand_b = opnd_b[1];
	assign alu1.rd = u_rd[1];

	//////////////////////////////////////////////////////////////////////
	// state update
	//////////////////////////////////////////////////////////////////////

	// per unit only one of writeback, dispatch or issue applies at a time
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int u = 0; u < NUM_ALUS; u++) begin
				u_state[u] <= UNIT_FREE;
				u_opnd_a[u] <= OPND_READY;
				u_opnd_b[u] <= OPND_READY;
			end
			for (int r = 0; r < NUM_REGS; r++) begin
				reg_pending[r] <= 1'b0;
			end
		end else begin
			for (int u = 0; u < NUM_ALUS; u++) begin
				if (wb_valid[u]) begin
					u_state[u] <= UNIT_FREE;
					reg_pending[wb_rd[u]] <= 1'b0;
				end
				if (disp_go[u]) begin
					u_state[u] <= UNIT_WORKING;
				end
				// wakeup
				if (u_opnd_a[u] == OPND_PENDING && wb_valid[u_prod_a[u]]) begin
					u_opnd_a[u] <= OPND_READY;
				end
				if (u_opnd_b[u] == OPND_PENDING && wb_valid[u_prod_b[u]]) begin
					u_opnd_b[u] <= OPND_READY;
				end
			end
			if (issue_go) begin
				u_state[free_unit] <= UNIT_WAITING;
				u_opnd_a[free_unit] <= src_a_wait ? OPND_PENDING : OPND_READY;
				if (iss.use_imm) begin
					u_opnd_b[free_unit] <= OPND_IMMEDIATE;
				end else begin
					u_opnd_b[free_unit] <= src_b_wait ? OPND_PENDING : OPND_READY;
				end
				reg_pending[iss.rd] <= 1'b1;
			end
		end
	end

	// entry payload, only meaningful while the unit is busy
	always_ff @(posedge clk) begin
		if (issue_go) begin
			u_op[free_unit] <= iss.op;
			u_rd[free_unit] <= iss.rd;
			u_src_a[free_unit] <= iss.rs;
			u_src_b[free_unit] <= iss.rt;
			u_prod_a[free_unit] <= reg_producer[iss.rs];
			u_prod_b[free_unit] <= reg_producer[iss.rt];
			u_imm[free_unit] <= iss.imm;
			reg_producer[iss.rd] <= free_unit;
		end
	end

endmodule

//--- hw/front_end.sv
`timescale 1ns/1ps

module front_end
	import isa_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	output word_t   fetch_addr,
	input  instr_t  instruction,
	issue_if.source iss
);

	word_t  pc;
	logic   fetched;
	logic   hold_valid;
	instr_t hold_word;
	instr_t cur_word;
	logic   known;

	//////////////////////////////////////////////////////////////////////
	// fetch
	//////////////////////////////////////////////////////////////////////

	// rom answers one cycle late, so nothing to decode right after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			fetched <= 1'b0;
		end else begin
			fetched <= 1'b1;
			if (!iss.stall) begin
				pc <= pc + 1'b1;
			end
		end
	end

	assign fetch_addr = pc;

	// the word being stalled on is kept until stall drops;
	// pc holds meanwhile so the next word is fetched again
	always_ff @(posedge clk) begin
		if (rst) begin
			hold_valid <= 1'b0;
		end else begin
			hold_valid <= iss.stall;
		end
	end

	always_ff @(posedge clk) begin
		if (iss.stall && !hold_valid) begin
			hold_word <= instruction;
		end
	end

	assign cur_word = hold_valid ? hold_word : instruction;

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		known = 1'b1;
		iss.op = ALU_ADD;
		iss.use_imm = 1'b0;
		case (cur_word[OPC_MSB:OPC_LSB])
			OP_ADDI: begin
				iss.op = ALU_ADD;
				iss.use_imm = 1'b1;
			end
			OP_ADD: iss.op = ALU_ADD;
			OP_SUBI: begin
				iss.op = ALU_SUB;
				iss.use_imm = 1'b1;
			end
			OP_SUB: iss.op = ALU_SUB;
			// anything else is dropped
			default: known = 1'b0;
		endcase
	end

	assign iss.valid = fetched && known;
	assign iss.rd = cur_word[RD_LSB +: $bits(reg_idx_t)];
	assign iss.rs = cur_word[RS_LSB +: $bits(reg_idx_t)];
	assign iss.rt = cur_word[RT_LSB +: $bits(reg_idx_t)];

	// sign extend imm5
	assign iss.imm = {{($bits(word_t) - IMM_W){cur_word[RT_LSB + IMM_W - 1]}},
		cur_word[RT_LSB +: IMM_W]};

endmodule

//--- hw/cpu_ifs.sv
`timescale 1ns/1ps

// decoded instruction from front end to scoreboard
interface issue_if import isa_pkg::*; ();

	logic     valid;
	alu_op_t  op;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rt;
	logic     use_imm;
	word_t    imm;
	logic     stall;

	modport source (
		output valid, op, rd, rs, rt, use_imm, imm,
		input  stall
	);

	modport sink (
		input  valid, op, rd, rs, rt, use_imm, imm,
		output stall
	);

endinterface

// one per alu, start is a single-cycle strobe
interface dispatch_if import isa_pkg::*; ();

	logic     start;
	alu_op_t  op;
	word_t    operand_a;
	word_t    operand_b;
	reg_idx_t rd;

	modport issuer (output start, op, operand_a, operand_b, rd);

	modport unit (input start, op, operand_a, operand_b, rd);

endinterface

//--- hw/sched_pkg.sv
package sched_pkg;

	//////////////////////////////////////////////////////////////////////
	// scoreboard bookkeeping
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_ALUS = 2;

	// which alu produces a pending value
	typedef logic [0:0] unit_id_t;

	// free -> waiting on issue, waiting -> working on dispatch,
	// working -> free on writeback
	typedef enum logic [1:0] {
		UNIT_FREE    = 2'd0,
		UNIT_WAITING = 2'd1,
		UNIT_WORKING = 2'd2
	} unit_state_t;

	// immediate operands never wait
	typedef enum logic [1:0] {
		OPND_READY     = 2'd0,
		OPND_PENDING   = 2'd1,
		OPND_IMMEDIATE = 2'd2
	} operand_state_t;

endpackage

//--- hw/isa_pkg.sv
package isa_pkg;

	//////////////////////////////////////////////////////////////////////
	// instruction word layout
	//////////////////////////////////////////////////////////////////////

	localparam int NUM_REGS = 8;

	// opcode field
	localparam int OPC_MSB = 15;
	localparam int OPC_LSB = 11;

	// register fields, lsb of each 3-bit slice
	localparam int RD_LSB = 8;
	localparam int RS_LSB = 5;
	localparam int RT_LSB = 0;

	// immediate shares the low bits with rt
	localparam int IMM_W = 5;

	//////////////////////////////////////////////////////////////////////
	// word types
	//////////////////////////////////////////////////////////////////////

	typedef logic [15:0] word_t;
	typedef logic [15:0] instr_t;
	typedef logic [2:0] reg_idx_t;

	// low bit of the opcode selects register form
	typedef enum logic [4:0] {
		OP_ADDI = 5'b00000,
		OP_ADD  = 5'b00001,
		OP_SUBI = 5'b00010,
		OP_SUB  = 5'b00011
	} opcode_t;

	typedef enum logic {
		ALU_ADD = 1'b0,
		ALU_SUB = 1'b1
	} alu_op_t;

endpackage
